// ==== vlog.f ====
rtl/lsu_pkg.sv
rtl/lsu_ecc_check.sv
rtl/lsu_pipe_ctl.sv
rtl/lsu_dccm_ctl.sv
rtl/lsu.sv
verification/dccm_model.sv
verification/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  # Package first, leaf modules before the top level
  - rtl/lsu_pkg.sv
  - rtl/lsu_ecc_check.sv
  - rtl/lsu_pipe_ctl.sv
  - rtl/lsu_dccm_ctl.sv
  - rtl/lsu.sv

  # DCCM model and testbench top lsu_tb
  - target: test
    files:
      - verification/dccm_model.sv
      - verification/lsu_tb.sv

// ==== verification/lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
   import lsu_pkg::*;
();

   localparam int DCCM_ADDR_W = 10;
   localparam int MAX_CYCLES  = 2000;       // Tests take well under 300 cycles

   logic                   clk, rst;
   logic                   dec_tlu_i0_kill_writeb_r, dec_lsu_valid_raw_d;
   addr_t                  exu_lsu_rs1_d;
   data_t                  exu_lsu_rs2_d;
   offset_t                dec_lsu_offset_d;
   lsu_pkt_t               lsu_p;
   data_t                  lsu_result_m, lsu_result_corr_r;
   logic                   lsu_load_stall_any, lsu_store_stall_any;
   logic                   lsu_idle_any, lsu_active, lsu_single_ecc_error_incr;
   lsu_error_pkt_t         lsu_error_pkt_r;
   logic                   dccm_wren, dccm_rden;
   logic [DCCM_ADDR_W-1:0] dccm_wr_addr, dccm_rd_addr;
   code_t                  dccm_wr_data, dccm_rd_data;
   logic                   dma_dccm_req, dma_mem_write;
   dma_tag_t               dma_mem_tag, dccm_dma_rtag;
   addr_t                  dma_mem_addr;
   data_t                  dma_mem_wdata, dccm_dma_rdata;
   logic                   dccm_dma_rvalid, dccm_dma_ecc_error, dccm_ready;

   data_t  ref_mem [0:(1<<DCCM_ADDR_W)-1];  // Expected DCCM words
   integer seed;
   int     errors = 0;
   int     fails  = 0;
   int     tests  = 0;
   int     cycles = 0;

   lsu #(
      .DCCM_ADDR_W (DCCM_ADDR_W)
   ) u_lsu (.*);

   dccm_model #(
      .DCCM_ADDR_W (DCCM_ADDR_W)
   ) u_dccm (
      .clk     (clk),
      .rden    (dccm_rden),
      .wren    (dccm_wren),
      .rd_addr (dccm_rd_addr),
      .wr_addr (dccm_wr_addr),
      .wr_data (dccm_wr_data),
      .rd_data (dccm_rd_data)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: tests still running after %0d cycles", cycles);
         $display("sim failed");
         $finish;
      end
   end

   // ************************************************************************
   // Compare tasks and expected-value helpers
   // ************************************************************************
   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_err_pkt(input string name, input lsu_error_pkt_t got,
                                input lsu_error_pkt_t exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   function automatic lsu_error_pkt_t make_err_pkt(input logic exc, input logic sec,
                                                   input logic ld, input logic mis,
                                                   input addr_t a);
      lsu_error_pkt_t e;
      e.exc_valid        = exc;
      e.single_ecc_error = sec;
      e.is_load          = ld;
      e.misaligned       = mis;
      e.addr             = a;
      return e;
   endfunction

   function automatic lsu_pkt_t make_pkt(input logic ld, input int bytes, input logic uns);
      lsu_pkt_t p;
      p        = '0;
      p.valid  = 1'b1;
      p.load   = ld;
      p.store  = ~ld;
      p.by     = (bytes == 1);
      p.half   = (bytes == 2);
      p.word   = (bytes == 4);
      p.unsign = uns;
      return p;
   endfunction

   function automatic int unsigned word_index(input addr_t a);
      return a[DCCM_ADDR_W+1:2];               // Word address above bit 1
   endfunction

   function automatic data_t expect_load(input data_t word, input logic [1:0] off,
                                         input lsu_pkt_t p);
      logic [7:0]  b;
      logic [15:0] h;
      b = word[8*off +: 8];
      h = word[16*off[1] +: 16];               // Aligned halves only
      if (p.by) return p.unsign ? {24'h0, b} : {{24{b[7]}}, b};
      if (p.half) return p.unsign ? {16'h0, h} : {{16{h[15]}}, h};
      return word;
   endfunction

   function automatic data_t merge_store(input data_t old, input data_t wdata,
                                         input logic [1:0] off, input lsu_pkt_t p);
      data_t res;
      res = old;
      if (p.by) res[8*off +: 8] = wdata[7:0];
      else if (p.half) res[16*off[1] +: 16] = wdata[15:0];
      else res = wdata;
      return res;
   endfunction

   // ************************************************************************
   // Bus-level drivers, all start and end 1 ns after a rising edge
   // ************************************************************************
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // One op into D, base and negative offset so the adder is exercised
   task automatic issue(input lsu_pkt_t p, input addr_t addr, input data_t wdata);
      while (p.load ? lsu_load_stall_any : lsu_store_stall_any) next_cycle();
      lsu_p               = p;
      exu_lsu_rs1_d       = addr + 32'd16;
      dec_lsu_offset_d    = 12'hff0;
      exu_lsu_rs2_d       = wdata;
      dec_lsu_valid_raw_d = 1'b1;
      next_cycle();
      lsu_p               = '0;                // Now in M
      dec_lsu_valid_raw_d = 1'b0;
   endtask

   task automatic do_load(input lsu_pkt_t p, input addr_t addr, output data_t res_m,
                          output data_t res_r, output lsu_error_pkt_t err,
                          output logic incr);
      issue(p, addr, '0);
      @(negedge clk);
      res_m = lsu_result_m;
      next_cycle();
      @(negedge clk);                          // R stage
      res_r = lsu_result_corr_r;
      err   = lsu_error_pkt_r;
      incr  = lsu_single_ecc_error_incr;
      next_cycle();
   endtask

   task automatic do_store(input lsu_pkt_t p, input addr_t addr, input data_t wdata,
                           input logic kill, output lsu_error_pkt_t err);
      issue(p, addr, wdata);
      next_cycle();
      dec_tlu_i0_kill_writeb_r = kill;         // Commit decision in R
      @(negedge clk);
      err = lsu_error_pkt_r;
      next_cycle();
      dec_tlu_i0_kill_writeb_r = 1'b0;
   endtask

   task automatic store_and_track(input addr_t addr, input int bytes, input data_t wdata);
      lsu_pkt_t       p;
      lsu_error_pkt_t err;
      p = make_pkt(1'b0, bytes, 1'b0);
      do_store(p, addr, wdata, 1'b0, err);
      check_err_pkt("lsu_error_pkt_r", err, make_err_pkt(1'b0, 1'b0, 1'b0, 1'b0, addr));
      ref_mem[word_index(addr)] = merge_store(ref_mem[word_index(addr)], wdata, addr[1:0], p);
   endtask

   task automatic check_load(input addr_t addr, input int bytes, input logic uns);
      lsu_pkt_t       p;
      data_t          exp, rm, rr;
      lsu_error_pkt_t err;
      logic           incr;
      p   = make_pkt(1'b1, bytes, uns);
      exp = expect_load(ref_mem[word_index(addr)], addr[1:0], p);
      do_load(p, addr, rm, rr, err, incr);
      check_data("lsu_result_m", rm, exp);
      check_data("lsu_result_corr_r", rr, exp);
      check_err_pkt("lsu_error_pkt_r", err, make_err_pkt(1'b0, 1'b0, 1'b1, 1'b0, addr));
      check_bit("lsu_single_ecc_error_incr", incr, 1'b0);
   endtask

   // Holds the request until dccm_ready lets it in
   task automatic dma_op(input logic wr, input addr_t addr, input data_t wdata,
                         input dma_tag_t tag);
      dma_dccm_req  = 1'b1;
      dma_mem_write = wr;
      dma_mem_addr  = addr;
      dma_mem_wdata = wdata;
      dma_mem_tag   = tag;
      @(negedge clk);
      while (!dccm_ready) @(negedge clk);
      next_cycle();                            // Accepted at that edge
      dma_dccm_req  = 1'b0;
   endtask

   task automatic check_status(input logic ld_stall, input logic st_stall, input logic idle);
      @(negedge clk);
      check_bit("lsu_load_stall_any", lsu_load_stall_any, ld_stall);
      check_bit("lsu_store_stall_any", lsu_store_stall_any, st_stall);
      check_bit("lsu_idle_any", lsu_idle_any, idle);
   endtask

   task automatic finish_test(input string name, input int err_before);
      tests++;
      if (errors == err_before) begin
         $display("%s: ok", name);
      end else begin
         fails++;
         $display("%s: FAIL with %0d errors", name, errors - err_before);
      end
   endtask

   // ************************************************************************
   // Tests
   // ************************************************************************
   task automatic test_status();
      int    e0;
      data_t d;
      e0 = errors;
      check_status(1'b0, 1'b0, 1'b1);          // Straight out of reset
      check_bit("lsu_active", lsu_active, 1'b0);
      next_cycle();
      d = $random(seed);
      issue(make_pkt(1'b0, 4, 1'b0), 32'h300, d);
      check_status(1'b1, 1'b1, 1'b0);          // Store in M
      check_bit("lsu_active", lsu_active, 1'b1);
      next_cycle();
      check_status(1'b1, 1'b1, 1'b0);          // Store in R
      ref_mem[word_index(32'h300)] = d;
      next_cycle();
      check_status(1'b0, 1'b0, 1'b1);
      next_cycle();
      finish_test("status", e0);
   endtask

   task automatic test_word();
      int e0;
      e0 = errors;
      store_and_track(32'h40, 4, $random(seed));
      check_load(32'h40, 4, 1'b0);
      check_load(32'h300, 4, 1'b0);            // Word left by the status test
      finish_test("word", e0);
   endtask

   task automatic test_byte_half();
      int e0;
      e0 = errors;
      store_and_track(32'h80, 4, $random(seed));
      store_and_track(32'h81, 1, $random(seed) | 32'h80);     // Negative byte
      store_and_track(32'h82, 2, $random(seed) | 32'h8000);   // Negative half
      check_load(32'h81, 1, 1'b0);
      check_load(32'h81, 1, 1'b1);
      check_load(32'h83, 1, 1'b0);
      check_load(32'h82, 2, 1'b0);
      check_load(32'h82, 2, 1'b1);
      check_load(32'h80, 2, 1'b1);
      check_load(32'h80, 4, 1'b0);
      finish_test("byte_half", e0);
   endtask

   task automatic test_single_ecc();
      int             e0;
      int             flip_pos [2] = '{13, 34};   // One data bit, one check bit
      data_t          d, rm, rr;
      lsu_error_pkt_t err;
      logic           incr;
      e0 = errors;
      d  = $random(seed);
      store_and_track(32'hc0, 4, d);
      foreach (flip_pos[i]) begin
         u_dccm.flip_bit(word_index(32'hc0), flip_pos[i]);
         do_load(make_pkt(1'b1, 4, 1'b0), 32'hc0, rm, rr, err, incr);
         check_data("lsu_result_m", rm, d);
         check_data("lsu_result_corr_r", rr, d);
         check_err_pkt("lsu_error_pkt_r", err, make_err_pkt(1'b0, 1'b1, 1'b1, 1'b0, 32'hc0));
         check_bit("lsu_single_ecc_error_incr", incr, 1'b1);
         @(negedge clk);                       // Scrub slot after R
         check_bit("dccm_wren", dccm_wren, 1'b1);
         next_cycle();
         check_load(32'hc0, 4, 1'b0);          // Clean after scrub
      end
      finish_test("single_ecc", e0);
   endtask

   task automatic test_exceptions();
      int             e0;
      data_t          rm, rr;
      lsu_error_pkt_t err;
      logic           incr;
      e0 = errors;
      store_and_track(32'h100, 4, $random(seed));
      u_dccm.flip_bit(word_index(32'h100), 3);
      u_dccm.flip_bit(word_index(32'h100), 17);
      do_load(make_pkt(1'b1, 4, 1'b0), 32'h100, rm, rr, err, incr);
      check_err_pkt("lsu_error_pkt_r", err, make_err_pkt(1'b1, 1'b0, 1'b1, 1'b0, 32'h100));
      check_bit("lsu_single_ecc_error_incr", incr, 1'b0);
      store_and_track(32'h140, 4, $random(seed));
      do_load(make_pkt(1'b1, 2, 1'b0), 32'h141, rm, rr, err, incr);
      check_err_pkt("lsu_error_pkt_r", err, make_err_pkt(1'b1, 1'b0, 1'b1, 1'b1, 32'h141));
      do_store(make_pkt(1'b0, 4, 1'b0), 32'h142, $random(seed), 1'b0, err);
      check_err_pkt("lsu_error_pkt_r", err, make_err_pkt(1'b1, 1'b0, 1'b0, 1'b1, 32'h142));
      check_load(32'h140, 4, 1'b0);            // Misaligned store wrote nothing
      do_store(make_pkt(1'b0, 4, 1'b0), 32'h140, $random(seed), 1'b1, err);
      check_err_pkt("lsu_error_pkt_r", err, make_err_pkt(1'b0, 1'b0, 1'b0, 1'b0, 32'h140));
      check_load(32'h140, 4, 1'b0);            // Killed store wrote nothing
      finish_test("exceptions", e0);
   endtask

   task automatic test_dma();
      int    e0;
      data_t d;
      e0 = errors;
      d  = $random(seed);
      dma_op(1'b1, 32'h200, d, 3'd5);
      ref_mem[word_index(32'h200)] = d;
      dma_op(1'b0, 32'h200, '0, 3'd3);
      @(negedge clk);                          // Cycle after acceptance
      check_bit("dccm_dma_rvalid", dccm_dma_rvalid, 1'b1);
      check_data("dccm_dma_rtag", data_t'(dccm_dma_rtag), 32'd3);
      check_data("dccm_dma_rdata", dccm_dma_rdata, d);
      check_bit("dccm_dma_ecc_error", dccm_dma_ecc_error, 1'b0);
      next_cycle();
      dec_lsu_valid_raw_d = 1'b1;              // Decode claims the DCCM
      @(negedge clk);
      check_bit("dccm_ready", dccm_ready, 1'b0);
      next_cycle();
      dec_lsu_valid_raw_d = 1'b0;
      @(negedge clk);
      check_bit("dccm_ready", dccm_ready, 1'b1);
      next_cycle();
      check_load(32'h200, 4, 1'b0);
      u_dccm.flip_bit(word_index(32'h200), 5);
      u_dccm.flip_bit(word_index(32'h200), 36);
      dma_op(1'b0, 32'h200, '0, 3'd6);
      @(negedge clk);                          // Uncorrectable word
      check_bit("dccm_dma_rvalid", dccm_dma_rvalid, 1'b1);
      check_bit("dccm_dma_ecc_error", dccm_dma_ecc_error, 1'b1);
      next_cycle();
      finish_test("dma", e0);
   endtask

   initial begin
      seed                     = 32'hd22b89ff;
      rst                      = 1'b1;
      dec_tlu_i0_kill_writeb_r = 1'b0;
      dec_lsu_valid_raw_d      = 1'b0;
      exu_lsu_rs1_d            = '0;
      exu_lsu_rs2_d            = '0;
      dec_lsu_offset_d         = '0;
      lsu_p                    = '0;
      dma_dccm_req             = 1'b0;
      dma_mem_write            = 1'b0;
      dma_mem_tag              = '0;
      dma_mem_addr             = '0;
      dma_mem_wdata            = '0;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
      test_status();
      test_word();
      test_byte_half();
      test_single_ecc();
      test_exceptions();
      test_dma();
      $display("tests %0d, failed tests %0d, failed checks %0d", tests, fails, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verification/dccm_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module dccm_model
   import lsu_pkg::*;
#(
   parameter int DCCM_ADDR_W = 10
) (
   input  logic                   clk,
   input  logic                   rden,
   input  logic                   wren,
   input  logic [DCCM_ADDR_W-1:0] rd_addr,
   input  logic [DCCM_ADDR_W-1:0] wr_addr,
   input  code_t                  wr_data,
   output code_t                  rd_data       // One cycle after rden
);

   code_t mem [0:(1<<DCCM_ADDR_W)-1];

   // All-zero word is a valid codeword, so unwritten reads stay clean
   initial begin
      for (int i = 0; i < (1 << DCCM_ADDR_W); i++) begin
         mem[i] = '0;
      end
   end

   always @(posedge clk) begin
      if (rden) rd_data <= mem[rd_addr];   // Old word on same-cycle write
      if (wren) mem[wr_addr] <= wr_data;
   end

   // Backdoor error injection, data bits 0..31, check bits 32..38
   task automatic flip_bit(input int unsigned addr, input int unsigned pos);
      mem[addr][pos] = ~mem[addr][pos];
   endtask

endmodule

`default_nettype wire

// ==== rtl/lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu
   import lsu_pkg::*;
#(
   parameter int DCCM_ADDR_W = 10          // DCCM word address bits
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   dec_tlu_i0_kill_writeb_r,
   input  addr_t                  exu_lsu_rs1_d,
   input  data_t                  exu_lsu_rs2_d,
   input  offset_t                dec_lsu_offset_d,
   input  lsu_pkt_t               lsu_p,
   input  logic                   dec_lsu_valid_raw_d,
   output data_t                  lsu_result_m,
   output data_t                  lsu_result_corr_r,
   output logic                   lsu_load_stall_any,
   output logic                   lsu_store_stall_any,
   output logic                   lsu_idle_any,
   output logic                   lsu_active,
   output logic                   lsu_single_ecc_error_incr,
   output lsu_error_pkt_t         lsu_error_pkt_r,
   // DCCM
   output logic                   dccm_wren,
   output logic                   dccm_rden,
   output logic [DCCM_ADDR_W-1:0] dccm_wr_addr,
   output logic [DCCM_ADDR_W-1:0] dccm_rd_addr,
   output code_t                  dccm_wr_data,
   input  code_t                  dccm_rd_data,
   // DMA
   input  logic                   dma_dccm_req,
   input  dma_tag_t               dma_mem_tag,
   input  addr_t                  dma_mem_addr,
   input  logic                   dma_mem_write,
   input  data_t                  dma_mem_wdata,
   output logic                   dccm_dma_rvalid,
   output logic                   dccm_dma_ecc_error,
   output dma_tag_t               dccm_dma_rtag,
   output data_t                  dccm_dma_rdata,
   output logic                   dccm_ready
);

   addr_t    lsu_addr_d, lsu_addr_m;
   lsu_pkt_t lsu_pkt_m, lsu_pkt_r;
   logic     wr_en_r;
   logic     single_err_m, double_err_m;
   logic     scrub_pend;
   logic     dma_accept;

   // Address, pipe control, error packet
   lsu_pipe_ctl u_pipe_ctl (.*);

   // DCCM ports, ECC, load data and DMA
   lsu_dccm_ctl #(
      .DCCM_ADDR_W (DCCM_ADDR_W)
   ) u_dccm_ctl (
      .lsu_acc_d (lsu_p.valid & (lsu_p.load | lsu_p.store)),
      .*
   );

endmodule

`default_nettype wire

// ==== rtl/lsu_dccm_ctl.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_dccm_ctl
   import lsu_pkg::*;
#(
   parameter int DCCM_ADDR_W = 10
) (
   input  logic                   clk,
   input  logic                   rst,
   input  addr_t                  lsu_addr_d,
   input  logic                   lsu_acc_d,       // Valid load or store in D
   input  lsu_pkt_t               lsu_pkt_m,
   input  addr_t                  lsu_addr_m,
   input  lsu_pkt_t               lsu_pkt_r,
   input  logic                   wr_en_r,         // Store commit
   input  data_t                  exu_lsu_rs2_d,   // Store data
   input  logic                   dccm_ready,
   input  logic                   dma_dccm_req,
   input  dma_tag_t               dma_mem_tag,
   input  addr_t                  dma_mem_addr,
   input  logic                   dma_mem_write,
   input  data_t                  dma_mem_wdata,
   input  code_t                  dccm_rd_data,    // One cycle after rden
   output logic                   dccm_rden,
   output logic                   dccm_wren,
   output logic [DCCM_ADDR_W-1:0] dccm_rd_addr,
   output logic [DCCM_ADDR_W-1:0] dccm_wr_addr,
   output code_t                  dccm_wr_data,
   output data_t                  lsu_result_m,
   output data_t                  lsu_result_corr_r,
   output logic                   single_err_m,
   output logic                   double_err_m,
   output logic                   scrub_pend,
   output logic                   dma_accept,
   output logic                   dccm_dma_rvalid,
   output logic                   dccm_dma_ecc_error,
   output dma_tag_t               dccm_dma_rtag,
   output data_t                  dccm_dma_rdata
);

   logic                   dma_rd, dma_wr;
   data_t                  corr_data;
   logic                   sec, ded;
   data_t                  store_data_m, st_shift, ld_shift, merged_m;
   logic [3:0]             be_m;            // Store byte lanes
   code_t                  code_r, scrub_code;
   logic [DCCM_ADDR_W-1:0] waddr_r, scrub_addr;
   logic                   ld_single_r;

   // ************************************************************************
   // Port arbitration
   // ************************************************************************
   assign dma_accept = dma_dccm_req & dccm_ready;
   assign dma_rd     = dma_accept & ~dma_mem_write;
   assign dma_wr     = dma_accept & dma_mem_write;

   assign dccm_rden    = lsu_acc_d | dma_rd;          // Every store reads too
   assign dccm_rd_addr = dma_rd ? dma_mem_addr[DCCM_ADDR_W+1:2] : lsu_addr_d[DCCM_ADDR_W+1:2];

   // Scrub first, then committed store, then DMA
   assign dccm_wren = scrub_pend | wr_en_r | dma_wr;
   always_comb begin
      if (scrub_pend) begin
         dccm_wr_addr = scrub_addr;
         dccm_wr_data = scrub_code;
      end else if (wr_en_r) begin
         dccm_wr_addr = waddr_r;
         dccm_wr_data = code_r;
      end else begin
         dccm_wr_addr = dma_mem_addr[DCCM_ADDR_W+1:2];
         dccm_wr_data = {ecc_encode(dma_mem_wdata), dma_mem_wdata};
      end
   end

   // ************************************************************************
   // M stage, check, extract, merge
   // ************************************************************************
   lsu_ecc_check u_ecc_check (
      .code_in    (dccm_rd_data),
      .data_out   (corr_data),
      .single_err (sec),
      .double_err (ded)
   );

   assign single_err_m = lsu_pkt_m.valid & sec;
   assign double_err_m = lsu_pkt_m.valid & ded;

   assign ld_shift = corr_data >> {lsu_addr_m[1:0], 3'b000};
   always_comb begin
      if (lsu_pkt_m.by)
         lsu_result_m = {{24{~lsu_pkt_m.unsign & ld_shift[7]}}, ld_shift[7:0]};
      else if (lsu_pkt_m.half)
         lsu_result_m = {{16{~lsu_pkt_m.unsign & ld_shift[15]}}, ld_shift[15:0]};
      else
         lsu_result_m = ld_shift;
   end

   // Loads get no lanes, so merged_m is the corrected word for scrub
   assign be_m = {4{lsu_pkt_m.store}} &
                 ((lsu_pkt_m.by ? 4'b0001 : lsu_pkt_m.half ? 4'b0011 : 4'b1111) << lsu_addr_m[1:0]);
   assign st_shift = store_data_m << {lsu_addr_m[1:0], 3'b000};
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         merged_m[8*i +: 8] = be_m[i] ? st_shift[8*i +: 8] : corr_data[8*i +: 8];
      end
   end

   // ************************************************************************
   // Stage registers
   // ************************************************************************
   always_ff @(posedge clk) begin
      store_data_m      <= exu_lsu_rs2_d;
      code_r            <= {ecc_encode(merged_m), merged_m};
      waddr_r           <= lsu_addr_m[DCCM_ADDR_W+1:2];
      ld_single_r       <= lsu_pkt_m.load & single_err_m;
      lsu_result_corr_r <= lsu_result_m;
      scrub_code        <= code_r;        // Hold past R, M moves on
      scrub_addr        <= waddr_r;
      dccm_dma_rtag     <= dma_mem_tag;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         scrub_pend      <= 1'b0;
         dccm_dma_rvalid <= 1'b0;
      end else begin
         scrub_pend      <= lsu_pkt_r.valid & lsu_pkt_r.load & ld_single_r;
         dccm_dma_rvalid <= dma_rd;
      end
   end

   // DMA data returns with its read word
   assign dccm_dma_rdata     = corr_data;
   assign dccm_dma_ecc_error = dccm_dma_rvalid & ded;

endmodule

`default_nettype wire

// ==== rtl/lsu_pipe_ctl.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_pipe_ctl
   import lsu_pkg::*;
(
   input  logic           clk,
   input  logic           rst,
   input  lsu_pkt_t       lsu_p,                    // D-stage packet
   input  addr_t          exu_lsu_rs1_d,            // Base register
   input  offset_t        dec_lsu_offset_d,         // Immediate
   input  logic           dec_lsu_valid_raw_d,      // Raw decode valid
   input  logic           dec_tlu_i0_kill_writeb_r, // Kill store in R
   input  logic           single_err_m,             // ECC flags of M-stage read
   input  logic           double_err_m,
   input  logic           scrub_pend,               // Scrub write this cycle
   input  logic           dma_accept,               // DMA took the DCCM
   output addr_t          lsu_addr_d,
   output lsu_pkt_t       lsu_pkt_m,
   output addr_t          lsu_addr_m,
   output lsu_pkt_t       lsu_pkt_r,
   output logic           wr_en_r,                  // Store commit write
   output lsu_error_pkt_t lsu_error_pkt_r,
   output logic           lsu_single_ecc_error_incr,
   output logic           lsu_load_stall_any,
   output logic           lsu_store_stall_any,
   output logic           lsu_idle_any,
   output logic           lsu_active,
   output logic           dccm_ready                // Ready for DMA
);

   logic  misalign_d, misalign_m, misalign_r;
   addr_t lsu_addr_r;
   logic  single_r, double_r;
   logic  store_inflight;
   logic  ld_sec_m;
   logic  exc_r;

   // ************************************************************************
   // D stage
   // ************************************************************************
   assign lsu_addr_d = exu_lsu_rs1_d + {{20{dec_lsu_offset_d[11]}}, dec_lsu_offset_d};

   assign misalign_d = lsu_p.valid &
                       ((lsu_p.half & lsu_addr_d[0]) | (lsu_p.word & (|lsu_addr_d[1:0])));

   // ************************************************************************
   // Pipeline registers
   // ************************************************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         lsu_pkt_m <= '0;
         lsu_pkt_r <= '0;
      end else begin
         lsu_pkt_m <= lsu_p;      // Bubble when lsu_p.valid low
         lsu_pkt_r <= lsu_pkt_m;
      end
   end

   // Payload, qualified by the packet valids
   always_ff @(posedge clk) begin
      lsu_addr_m <= lsu_addr_d;
      misalign_m <= misalign_d;
      lsu_addr_r <= lsu_addr_m;
      misalign_r <= misalign_m;
      single_r   <= single_err_m;
      double_r   <= double_err_m;
   end

   // ************************************************************************
   // R stage, exceptions and store commit
   // ************************************************************************
   assign exc_r = lsu_pkt_r.valid & (misalign_r | (lsu_pkt_r.load & double_r));

   always_comb begin
      lsu_error_pkt_r.exc_valid        = exc_r;
      lsu_error_pkt_r.single_ecc_error = lsu_pkt_r.valid & lsu_pkt_r.load & single_r & ~exc_r;
      lsu_error_pkt_r.is_load          = lsu_pkt_r.load;
      lsu_error_pkt_r.misaligned       = misalign_r;    // Else double ECC
      lsu_error_pkt_r.addr             = lsu_addr_r;
   end

   assign wr_en_r = lsu_pkt_r.valid & lsu_pkt_r.store & ~dec_tlu_i0_kill_writeb_r & ~exc_r;

   // Counter pulse, scrub follows next cycle
   assign lsu_single_ecc_error_incr = lsu_pkt_r.valid & lsu_pkt_r.load & single_r;

   // ************************************************************************
   // Stalls and status
   // ************************************************************************
   assign store_inflight = (lsu_pkt_m.valid & lsu_pkt_m.store) |
                           (lsu_pkt_r.valid & lsu_pkt_r.store);

   // Load in M about to scrub, keeps a new store out of the scrub write slot
   assign ld_sec_m = lsu_pkt_m.load & single_err_m;

   assign lsu_load_stall_any  = store_inflight | scrub_pend;
   assign lsu_store_stall_any = store_inflight | scrub_pend | ld_sec_m;

   assign lsu_idle_any = ~(lsu_pkt_m.valid | lsu_pkt_r.valid | scrub_pend);
   assign lsu_active   = lsu_pkt_m.valid | lsu_pkt_r.valid | scrub_pend | dma_accept;

   // DMA kept off while decode has an LSU op or a write is coming
   assign dccm_ready = ~(dec_lsu_valid_raw_d | store_inflight | scrub_pend);

endmodule

`default_nettype wire

// ==== rtl/lsu_ecc_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_ecc_check
   import lsu_pkg::*;
(
   input  code_t code_in,     // Raw DCCM word
   output data_t data_out,    // Corrected data
   output logic  single_err,  // Correctable, data or check bit
   output logic  double_err   // Uncorrectable
);

   // ************************************************************************
   // Syndrome
   // ************************************************************************
   data_t      data_raw;
   ecc_t       ecc_raw;
   ecc_t       ecc_calc;
   logic [5:0] syndrome;
   logic       parity_odd;

   assign {ecc_raw, data_raw} = code_in;
   assign ecc_calc = ecc_encode(data_raw);                // Recompute from data
   assign syndrome = ecc_calc[5:0] ^ ecc_raw[5:0];       // Position of flipped bit

   // Overall parity of the whole stored word, rebuilt from the recomputed bits
   assign parity_odd = ecc_calc[6] ^ ecc_raw[6] ^ (^syndrome);

   // ************************************************************************
   // Correction
   // ************************************************************************
   always_comb begin
      data_out = data_raw;
      if (parity_odd) begin
         // Only flip when syndrome lands on a data slot
         for (int i = 0; i < DATA_W; i++) begin
            if (syndrome == ecc_data_pos(i)) data_out[i] = ~data_raw[i];
         end
      end
   end

   // Odd parity means one bit flipped
   // zero syndrome then points at the overall parity bit itself
   assign single_err = parity_odd;

   // Even parity with a syndrome means two bits flipped
   assign double_err = ~parity_odd & (syndrome != 6'd0);

endmodule

`default_nettype wire

// ==== rtl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

   // ************************************************************************
   // Widths and types
   // ************************************************************************
   localparam int DATA_W = 32;
   localparam int ECC_W  = 7;               // 6 Hamming bits + overall parity
   localparam int CODE_W = DATA_W + ECC_W;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ECC_W-1:0]  ecc_t;
   typedef logic [CODE_W-1:0] code_t;       // {ecc, data}
   typedef logic [31:0]       addr_t;       // Byte address
   typedef logic [11:0]       offset_t;     // Immediate offset
   typedef logic [2:0]        dma_tag_t;

   // Control packet, one-hot size in by/half/word
   typedef struct packed {
      logic valid;
      logic load;
      logic store;
      logic by;
      logic half;
      logic word;
      logic unsign;                         // Zero extend on load
   } lsu_pkt_t;

   typedef struct packed {
      logic  exc_valid;
      logic  single_ecc_error;
      logic  is_load;
      logic  misaligned;                    // 0 means ECC double error
      addr_t addr;
   } lsu_error_pkt_t;

   // ************************************************************************
   // SECDED helpers
   // ************************************************************************

   // Hamming position of data bit idx, power-of-two slots hold parity
   function automatic logic [5:0] ecc_data_pos(input int unsigned idx);
      int unsigned cnt;
      logic [5:0]  pos;
      cnt = 0;
      pos = '0;
      for (int unsigned p = 1; p < CODE_W; p++) begin
         if ((p & (p - 1)) != 0) begin
            if (cnt == idx) pos = 6'(p);
            cnt++;
         end
      end
      return pos;
   endfunction

   function automatic ecc_t ecc_encode(input data_t data);
      ecc_t       ecc;
      logic [5:0] pos;
      ecc = '0;
      for (int i = 0; i < DATA_W; i++) begin
         pos = ecc_data_pos(i);
         for (int j = 0; j < ECC_W - 1; j++) begin
            if (pos[j]) ecc[j] = ecc[j] ^ data[i];   // Parity j covers pos bit j
         end
      end
      ecc[ECC_W-1] = ^{data, ecc[ECC_W-2:0]};        // Overall parity
      return ecc;
   endfunction

endpackage

`default_nettype wire
